//--- soc_pkg.sv
package soc_pkg;

  // address map
  localparam logic [31:0] bram_base_addr  = 32'h0000_0000;
  localparam logic [31:0] bram_top_addr   = 32'h0000_0400;
  localparam logic [31:0] uart_base_addr  = 32'h1000_0000;
  localparam logic [31:0] uart_top_addr   = 32'h1000_0010;
  localparam logic [31:0] clint_base_addr = 32'h2000_0000;
  localparam logic [31:0] clint_top_addr  = 32'h2000_C000;

  // register offsets, relative to the slave base
  localparam logic [31:0] uart_data_off       = 32'h0000_0000;
  localparam logic [31:0] uart_status_off     = 32'h0000_0004;
  localparam logic [31:0] clint_msip_off      = 32'h0000_0000;
  localparam logic [31:0] clint_mtimecmp_off  = 32'h0000_4000;
  localparam logic [31:0] clint_mtimecmph_off = 32'h0000_4004;
  localparam logic [31:0] clint_mtime_off     = 32'h0000_BFF8;
  localparam logic [31:0] clint_mtimeh_off    = 32'h0000_BFFC;

  typedef enum logic [1:0] {sel_none, sel_bram, sel_uart, sel_clint} slave_sel_e;

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} uart_state_e;

  // byte-lane merge for strobed writes
  function automatic logic [31:0] strb_merge(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

//--- mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;
  logic        valid;  // one-cycle strobe
  logic        instr;
  logic [31:0] addr;   // offset within the slave
  logic [31:0] wdata;
  logic [3:0]  wstrb;  // zero for reads
  logic [31:0] rdata;
  logic        ready;  // one-cycle pulse

  modport master (
    output valid, instr, addr, wdata, wstrb,
    input  rdata, ready
  );

  modport slave (
    input  valid, instr, addr, wdata, wstrb,
    output rdata, ready
  );

endinterface

//--- tick_divider.sv
`timescale 1ns/1ps

module tick_divider #(
  parameter int DIV = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic clr_i,
  output logic tick_o
);
  localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

  logic [CW-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (!rst || clr_i) begin
      cnt_q <= '0;  // realign to the outside event
    end else if (cnt_q == CW'(DIV - 1)) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign tick_o = (cnt_q == CW'(DIV - 1));

endmodule

//--- bus_router.sv
`timescale 1ns/1ps

module bus_router (
  input  logic        clk,
  input  logic        rst,
  input  logic        imem_valid_i,
  input  logic        imem_instr_i,
  input  logic [31:0] imem_addr_i,
  input  logic [31:0] imem_wdata_i,
  input  logic [3:0]  imem_wstrb_i,
  output logic [31:0] imem_rdata_o,
  output logic        imem_ready_o,
  input  logic        dmem_valid_i,
  input  logic        dmem_instr_i,
  input  logic [31:0] dmem_addr_i,
  input  logic [31:0] dmem_wdata_i,
  input  logic [3:0]  dmem_wstrb_i,
  output logic [31:0] dmem_rdata_o,
  output logic        dmem_ready_o,
  mem_bus_if.master   bram_o,
  mem_bus_if.master   uart_o,
  mem_bus_if.master   clint_o
);
  import soc_pkg::*;

  slave_sel_e  i_hit, d_hit;
  slave_sel_e  i_sel_q, d_sel_q;
  logic [31:0] i_addr, d_addr;
  logic [32:0] bram_rsp, uart_rsp, clint_rsp;

  function automatic slave_sel_e decode(input logic [31:0] addr);
    if (addr >= clint_base_addr && addr < clint_top_addr) return sel_clint;
    if (addr >= uart_base_addr && addr < uart_top_addr) return sel_uart;
    if (addr >= bram_base_addr && addr < bram_top_addr) return sel_bram;
    return sel_none;
  endfunction

  function automatic logic [31:0] base_of(input slave_sel_e sel);
    case (sel)
      sel_bram:  return bram_base_addr;
      sel_uart:  return uart_base_addr;
      sel_clint: return clint_base_addr;
      default:   return '0;
    endcase
  endfunction

  // {ready, rdata} of the slave a port is waiting on
  function automatic logic [32:0] pick(input slave_sel_e sel, input logic [32:0] b,
                                       input logic [32:0] u, input logic [32:0] c);
    case (sel)
      sel_bram:  return b;
      sel_uart:  return u;
      sel_clint: return c;
      default:   return '0;
    endcase
  endfunction

  always_comb begin
    d_hit = dmem_valid_i ? decode(dmem_addr_i) : sel_none;
    i_hit = imem_valid_i ? decode(imem_addr_i) : sel_none;
    if (i_hit == d_hit) begin
      i_hit = sel_none;  // data port wins, fetch is dropped
    end
    d_addr = dmem_addr_i - base_of(decode(dmem_addr_i));
    i_addr = imem_addr_i - base_of(decode(imem_addr_i));
  end

  assign bram_o.valid  = (d_hit == sel_bram) || (i_hit == sel_bram);
  assign bram_o.instr  = (d_hit == sel_bram) ? dmem_instr_i : imem_instr_i;
  assign bram_o.addr   = (d_hit == sel_bram) ? d_addr : i_addr;
  assign bram_o.wdata  = (d_hit == sel_bram) ? dmem_wdata_i : imem_wdata_i;
  assign bram_o.wstrb  = (d_hit == sel_bram) ? dmem_wstrb_i : imem_wstrb_i;
  assign uart_o.valid  = (d_hit == sel_uart) || (i_hit == sel_uart);
  assign uart_o.instr  = (d_hit == sel_uart) ? dmem_instr_i : imem_instr_i;
  assign uart_o.addr   = (d_hit == sel_uart) ? d_addr : i_addr;
  assign uart_o.wdata  = (d_hit == sel_uart) ? dmem_wdata_i : imem_wdata_i;
  assign uart_o.wstrb  = (d_hit == sel_uart) ? dmem_wstrb_i : imem_wstrb_i;
  assign clint_o.valid = (d_hit == sel_clint) || (i_hit == sel_clint);
  assign clint_o.instr = (d_hit == sel_clint) ? dmem_instr_i : imem_instr_i;
  assign clint_o.addr  = (d_hit == sel_clint) ? d_addr : i_addr;
  assign clint_o.wdata = (d_hit == sel_clint) ? dmem_wdata_i : imem_wdata_i;
  assign clint_o.wstrb = (d_hit == sel_clint) ? dmem_wstrb_i : imem_wstrb_i;

  assign bram_rsp  = {bram_o.ready, bram_o.rdata};
  assign uart_rsp  = {uart_o.ready, uart_o.rdata};
  assign clint_rsp = {clint_o.ready, clint_o.rdata};

  assign {imem_ready_o, imem_rdata_o} = pick(i_sel_q, bram_rsp, uart_rsp, clint_rsp);
  assign {dmem_ready_o, dmem_rdata_o} = pick(d_sel_q, bram_rsp, uart_rsp, clint_rsp);

  always_ff @(posedge clk) begin
    if (!rst) begin
      i_sel_q <= sel_none;
      d_sel_q <= sel_none;
    end else begin
      if (imem_valid_i) begin
        i_sel_q <= i_hit;
      end else if (imem_ready_o) begin
        i_sel_q <= sel_none;
      end
      if (dmem_valid_i) begin
        d_sel_q <= d_hit;
      end else if (dmem_ready_o) begin
        d_sel_q <= sel_none;
      end
    end
  end

  // one owner per slave at a time
  assert property (@(posedge clk) disable iff (!rst)
    (i_sel_q == d_sel_q) |-> (d_sel_q == sel_none));

endmodule

//--- bram.sv
`timescale 1ns/1ps

module bram #(
  parameter int BRAM_WORDS = 256
) (
  input  logic     clk,
  input  logic     rst,
  mem_bus_if.slave bus_i
);
  import soc_pkg::*;

  localparam int AW = (BRAM_WORDS > 1) ? $clog2(BRAM_WORDS) : 1;

  logic [31:0]   mem [BRAM_WORDS];
  logic [AW-1:0] idx;
  logic [31:0]   rdata_q;
  logic          ready_q;

  assign idx = bus_i.addr[AW+1:2];  // word address

  always_ff @(posedge clk) begin
    if (bus_i.valid) begin
      if (bus_i.wstrb != 4'b0) begin
        mem[idx] <= strb_merge(mem[idx], bus_i.wdata, bus_i.wstrb);
      end
      rdata_q <= mem[idx];  // old word on a write
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= bus_i.valid;
    end
  end

  assign bus_i.rdata = rdata_q;
  assign bus_i.ready = ready_q;

  // request must fall inside the array, no aliasing
  assert property (@(posedge clk) disable iff (!rst)
    bus_i.valid |-> (bus_i.addr < 32'(BRAM_WORDS * 4)));

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int BAUD_DIV = 4
) (
  input  logic     clk,
  input  logic     rst,
  mem_bus_if.slave bus_i,
  output logic     tx_o
);
  import soc_pkg::*;

  uart_state_e state_q, state_d;
  logic [7:0]  shreg_q, shreg_d, pend_data_q;
  logic [2:0]  bitcnt_q, bitcnt_d;
  logic [31:0] rdata_q;
  logic        pend_q, ready_q, tx_q;
  logic        wr_data, busy, start, baud_tick;

  assign wr_data = bus_i.valid && (bus_i.wstrb != 4'b0) && (bus_i.addr == uart_data_off);
  assign busy    = (state_q != st_idle) || pend_q;
  assign start   = (state_q == st_idle) && (wr_data || pend_q);

  tick_divider #(.DIV(BAUD_DIV)) i_baud (
    .clk    (clk),
    .rst    (rst),
    .clr_i  (start),  // bit clock starts with the frame
    .tick_o (baud_tick)
  );

  always_comb begin
    state_d  = state_q;
    shreg_d  = shreg_q;
    bitcnt_d = bitcnt_q;
    case (state_q)
      st_idle: if (start) begin
        state_d = st_start;
        shreg_d = pend_q ? pend_data_q : bus_i.wdata[7:0];
      end
      st_start: if (baud_tick) begin
        state_d  = st_data;
        bitcnt_d = '0;
      end
      st_data: if (baud_tick) begin
        shreg_d  = shreg_q >> 1;  // lsb first
        bitcnt_d = bitcnt_q + 1'b1;
        if (bitcnt_q == 3'd7) begin
          state_d = st_stop;
        end
      end
      default: if (baud_tick) state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state_q  <= st_idle;
      bitcnt_q <= '0;
      pend_q   <= 1'b0;
      ready_q  <= 1'b0;
      tx_q     <= 1'b1;
    end else begin
      state_q  <= state_d;
      bitcnt_q <= bitcnt_d;
      tx_q     <= (state_d == st_start) ? 1'b0 : (state_d == st_data) ? shreg_d[0] : 1'b1;
      ready_q  <= (bus_i.valid && !(wr_data && busy)) || (start && pend_q);
      if (wr_data && busy) begin
        pend_q <= 1'b1;  // held until the frame is out
      end else if (start) begin
        pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    shreg_q <= shreg_d;
    if (wr_data && busy) begin
      pend_data_q <= bus_i.wdata[7:0];
    end
    if (bus_i.valid) begin
      rdata_q <= (bus_i.addr == uart_status_off) ? {31'b0, busy} : '0;
    end
  end

  assign bus_i.rdata = rdata_q;
  assign bus_i.ready = ready_q;
  assign tx_o        = tx_q;

  // a held byte is not overwritten while a frame is out
  assert property (@(posedge clk) disable iff (!rst)
    (wr_data && state_q != st_idle) |-> !pend_q);

endmodule

//--- clint.sv
`timescale 1ns/1ps

module clint #(
  parameter int RTC_DIV = 8
) (
  input  logic     clk,
  input  logic     rst,
  mem_bus_if.slave bus_i,
  output logic     msip_o,
  output logic     mtip_o
);
  import soc_pkg::*;

  logic        msip_q, ready_q;
  logic [63:0] mtime_q, mtimecmp_q;
  logic [31:0] rdata_q;
  logic        wr, mtime_wr, rtc_tick;

  assign wr       = bus_i.valid && (bus_i.wstrb != 4'b0);
  assign mtime_wr = wr && (bus_i.addr == clint_mtime_off || bus_i.addr == clint_mtimeh_off);

  tick_divider #(.DIV(RTC_DIV)) i_rtc (
    .clk    (clk),
    .rst    (rst),
    .clr_i  (mtime_wr),
    .tick_o (rtc_tick)
  );

  always_ff @(posedge clk) begin
    if (!rst) begin
      msip_q     <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // no timer irq until programmed
      ready_q    <= 1'b0;
    end else begin
      ready_q <= bus_i.valid;
      if (mtime_wr) begin
        if (bus_i.addr == clint_mtime_off) begin
          mtime_q[31:0] <= strb_merge(mtime_q[31:0], bus_i.wdata, bus_i.wstrb);
        end else begin
          mtime_q[63:32] <= strb_merge(mtime_q[63:32], bus_i.wdata, bus_i.wstrb);
        end
      end else if (rtc_tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr && bus_i.addr == clint_msip_off && bus_i.wstrb[0]) begin
        msip_q <= bus_i.wdata[0];
      end
      if (wr && bus_i.addr == clint_mtimecmp_off) begin
        mtimecmp_q[31:0] <= strb_merge(mtimecmp_q[31:0], bus_i.wdata, bus_i.wstrb);
      end
      if (wr && bus_i.addr == clint_mtimecmph_off) begin
        mtimecmp_q[63:32] <= strb_merge(mtimecmp_q[63:32], bus_i.wdata, bus_i.wstrb);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus_i.valid) begin
      case (bus_i.addr)
        clint_msip_off:      rdata_q <= {31'b0, msip_q};
        clint_mtimecmp_off:  rdata_q <= mtimecmp_q[31:0];
        clint_mtimecmph_off: rdata_q <= mtimecmp_q[63:32];
        clint_mtime_off:     rdata_q <= mtime_q[31:0];
        clint_mtimeh_off:    rdata_q <= mtime_q[63:32];
        default:             rdata_q <= '0;
      endcase
    end
  end

  assign bus_i.rdata = rdata_q;
  assign bus_i.ready = ready_q;
  assign msip_o      = msip_q;
  assign mtip_o      = (mtime_q >= mtimecmp_q);

endmodule

//--- soc.sv
`timescale 1ns/1ps

module soc #(
  parameter int BRAM_WORDS = 256,
  parameter int BAUD_DIV   = 4,
  parameter int RTC_DIV    = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        imem_valid_i,
  input  logic        imem_instr_i,
  input  logic [31:0] imem_addr_i,
  input  logic [31:0] imem_wdata_i,
  input  logic [3:0]  imem_wstrb_i,
  output logic [31:0] imem_rdata_o,
  output logic        imem_ready_o,
  input  logic        dmem_valid_i,
  input  logic        dmem_instr_i,
  input  logic [31:0] dmem_addr_i,
  input  logic [31:0] dmem_wdata_i,
  input  logic [3:0]  dmem_wstrb_i,
  output logic [31:0] dmem_rdata_o,
  output logic        dmem_ready_o,
  output logic        tx_o,
  output logic        mtip_o,
  output logic        msip_o
);

  mem_bus_if bram_bus ();
  mem_bus_if uart_bus ();
  mem_bus_if clint_bus ();

  // cpu ports share names with the router
  bus_router i_router (.*, .bram_o(bram_bus), .uart_o(uart_bus), .clint_o(clint_bus));

  bram #(.BRAM_WORDS(BRAM_WORDS)) i_bram (.clk(clk), .rst(rst), .bus_i(bram_bus));

  uart_tx #(.BAUD_DIV(BAUD_DIV)) i_uart (
    .clk   (clk),
    .rst   (rst),
    .bus_i (uart_bus),
    .tx_o  (tx_o)
  );

  clint #(.RTC_DIV(RTC_DIV)) i_clint (
    .clk    (clk),
    .rst    (rst),
    .bus_i  (clint_bus),
    .msip_o (msip_o),
    .mtip_o (mtip_o)
  );

endmodule

//--- tb_soc.sv
`timescale 1ns/1ps

module tb_soc;

  localparam int bram_words = 256;
  localparam int baud_div   = 4;
  localparam int rtc_div    = 8;
  localparam int max_cycles = 6000;  // tests need about 700 cycles

  localparam logic [31:0] uart_data   = 32'h1000_0000;
  localparam logic [31:0] uart_status = 32'h1000_0004;
  localparam logic [31:0] clint_msip  = 32'h2000_0000;
  localparam logic [31:0] clint_cmp   = 32'h2000_4000;
  localparam logic [31:0] clint_cmph  = 32'h2000_4004;
  localparam logic [31:0] clint_time  = 32'h2000_BFF8;
  localparam logic [31:0] clint_timeh = 32'h2000_BFFC;

  logic        clk = 1'b0;
  logic        rst;
  logic        imem_valid_i, imem_instr_i, dmem_valid_i, dmem_instr_i;
  logic [31:0] imem_addr_i, imem_wdata_i, dmem_addr_i, dmem_wdata_i;
  logic [3:0]  imem_wstrb_i, dmem_wstrb_i;
  logic [31:0] imem_rdata_o, dmem_rdata_o;
  logic        imem_ready_o, dmem_ready_o, tx_o, mtip_o, msip_o;

  integer      seed = 32'h3a73_19a4;
  int          cycle_cnt = 0;
  int          check_cnt = 0;
  int          err_cnt = 0;
  logic [31:0] shadow [bram_words];
  logic [7:0]  rx_q [$];  // bytes seen on tx_o

  soc #(.BRAM_WORDS(bram_words), .BAUD_DIV(baud_div), .RTC_DIV(rtc_div)) i_soc (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("run stopped, no end after %0d cycles", cycle_cnt);
      $display("Checks failed");
      $finish;
    end
  end

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic mtip_expected(input logic [63:0] mtime, input logic [63:0] mtimecmp);
    return mtime >= mtimecmp;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic require_ready(input logic ok, input string what);
    check_cnt++;
    if (!ok) begin
      err_cnt++;
      $display("no ready came for %s", what);
    end
  endtask

  task automatic dmem_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, input int max_wait,
                             output logic [31:0] rdata, output logic ok, output int lat);
    dmem_addr_i  = addr;
    dmem_wdata_i = wdata;
    dmem_wstrb_i = wstrb;
    dmem_valid_i = 1'b1;
    @(posedge clk);
    #1;
    dmem_valid_i = 1'b0;
    lat = 1;
    while (!dmem_ready_o && lat < max_wait) begin
      @(posedge clk);
      #1;
      lat++;
    end
    ok    = dmem_ready_o;
    rdata = dmem_rdata_o;
    @(posedge clk);
    #1;  // let the ready pulse end
  endtask

  task automatic imem_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, input int max_wait,
                             output logic [31:0] rdata, output logic ok, output int lat);
    imem_addr_i  = addr;
    imem_wdata_i = wdata;
    imem_wstrb_i = wstrb;
    imem_valid_i = 1'b1;
    @(posedge clk);
    #1;
    imem_valid_i = 1'b0;
    lat = 1;
    while (!imem_ready_o && lat < max_wait) begin
      @(posedge clk);
      #1;
      lat++;
    end
    ok    = imem_ready_o;
    rdata = imem_rdata_o;
    @(posedge clk);
    #1;
  endtask

  task automatic bus_access(input bit on_imem, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata, output int lat);
    logic ok;
    if (on_imem) begin
      imem_access(addr, wdata, wstrb, 4, rdata, ok, lat);
    end else begin
      dmem_access(addr, wdata, wstrb, 4, rdata, ok, lat);
    end
    require_ready(ok, on_imem ? "imem bram access" : "dmem bram access");
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic wait_for_bytes(input int n, input int limit);
    int waited = 0;
    while (rx_q.size() < n && waited < limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (rx_q.size() < n) begin
      err_cnt++;
      $display("uart sent %0d bytes, %0d expected", rx_q.size(), n);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s done, %0d errors", name, err_cnt - errs_before);
  endtask

  // uart monitor, samples mid-bit on the falling clock
  initial begin : uart_monitor
    logic       prev_tx;
    logic [7:0] rx_byte;
    prev_tx = 1'b1;
    forever begin
      @(negedge clk);
      if (prev_tx === 1'b1 && tx_o === 1'b0) begin
        repeat (baud_div / 2) @(negedge clk);
        check_value("tx_o start bit", 64'(tx_o), 64'h0);
        for (int i = 0; i < 8; i++) begin
          repeat (baud_div) @(negedge clk);
          rx_byte[i] = tx_o;
        end
        repeat (baud_div) @(negedge clk);
        check_value("tx_o stop bit", 64'(tx_o), 64'h1);
        rx_q.push_back(rx_byte);
      end
      prev_tx = tx_o;
    end
  end

  initial begin : main
    logic [31:0] rd, rd_i, w, lo, hi, t0, cmp_lo, cmp_hi;
    logic [3:0]  strb;
    logic [7:0]  b1, b2;
    logic        ok, ok_i;
    int          lat, lat_i, errs, c, t1, k;
    int          idx [8];
    rst          = 1'b0;
    imem_valid_i = 1'b0;
    imem_instr_i = 1'b1;
    imem_addr_i  = '0;
    imem_wdata_i = '0;
    imem_wstrb_i = '0;
    dmem_valid_i = 1'b0;
    dmem_instr_i = 1'b0;
    dmem_addr_i  = '0;
    dmem_wdata_i = '0;
    dmem_wstrb_i = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b1;
    idle_cycles(1);

    errs = err_cnt;
    for (int n = 0; n < 8; n++) begin
      idx[n] = $random(seed) & (bram_words - 1);
      w = $random(seed);
      bus_access(1'b0, 32'(idx[n]) << 2, w, 4'hf, rd, lat);  // full word first
      shadow[idx[n]] = w;
    end
    for (int n = 0; n < 20; n++) begin
      k    = $random(seed) & 7;
      w    = $random(seed);
      strb = 4'($random(seed));
      if (strb == 4'h0) strb = 4'h1;
      bus_access(n[0], 32'(idx[k]) << 2, w, strb, rd, lat);
      check_value("bram old word", 64'(rd), 64'(shadow[idx[k]]));
      check_value("bram ready latency", 64'(lat), 64'd1);
      shadow[idx[k]] = merge_bytes(shadow[idx[k]], w, strb);
    end
    for (int n = 0; n < 8; n++) begin
      bus_access(n[0], 32'(idx[n]) << 2, '0, 4'h0, rd, lat);
      check_value("bram rdata", 64'(rd), 64'(shadow[idx[n]]));
      check_value("bram ready latency", 64'(lat), 64'd1);
    end
    report_test("bram", errs);

    errs = err_cnt;
    fork
      dmem_access(32'(idx[0]) << 2, '0, 4'h0, 4, rd, ok, lat);
      imem_access(32'(idx[1]) << 2, '0, 4'h0, 4, rd_i, ok_i, lat_i);
    join
    require_ready(ok, "dmem read in a collision");
    check_value("dmem_rdata_o", 64'(rd), 64'(shadow[idx[0]]));
    check_value_plain : begin
      check_cnt++;
      if (ok_i) begin
        err_cnt++;
        $display("imem got a ready although the data port won the bram");
      end
    end
    imem_access(32'(idx[1]) << 2, '0, 4'h0, 4, rd_i, ok_i, lat_i);
    require_ready(ok_i, "reissued imem read");
    check_value("imem_rdata_o", 64'(rd_i), 64'(shadow[idx[1]]));
    report_test("collision", errs);

    errs = err_cnt;
    rx_q.delete();
    b1 = 8'hA5;
    b2 = 8'($random(seed));
    dmem_access(uart_data, 32'(b1), 4'h1, 4, rd, ok, lat);
    require_ready(ok, "uart data write");
    dmem_access(uart_data, 32'(b2), 4'h1, 100, rd, ok, lat);
    require_ready(ok, "second uart data write");
    wait_for_bytes(2, 200);
    check_value("uart byte 0", 64'(rx_q[0]), 64'(b1));
    check_value("uart byte 1", 64'(rx_q[1]), 64'(b2));
    idle_cycles(2 * baud_div);
    report_test("uart frame", errs);

    errs = err_cnt;
    rx_q.delete();
    b1 = 8'($random(seed));
    b2 = 8'($random(seed));
    c = cycle_cnt;
    dmem_access(uart_data, 32'(b1), 4'h1, 4, rd, ok, lat);
    require_ready(ok, "uart data write");
    t1 = c + lat;  // first frame starts here
    dmem_access(uart_status, '0, 4'h0, 4, rd, ok, lat);
    require_ready(ok, "uart status read");
    check_value("uart busy", 64'(rd[0]), 64'h1);
    c = cycle_cnt;
    dmem_access(uart_data, 32'(b2), 4'h1, 100, rd, ok, lat);
    require_ready(ok, "held uart data write");
    check_value("uart ready after stop bit", 64'(c + lat - t1 >= 10 * baud_div), 64'h1);
    wait_for_bytes(2, 200);
    check_value("uart byte 0", 64'(rx_q[0]), 64'(b1));
    check_value("uart byte 1", 64'(rx_q[1]), 64'(b2));
    idle_cycles(2 * baud_div);
    check_value("tx_o", 64'(tx_o), 64'h1);
    dmem_access(uart_status, '0, 4'h0, 4, rd, ok, lat);
    require_ready(ok, "uart status read");
    check_value("uart busy", 64'(rd[0]), 64'h0);
    report_test("uart back-pressure", errs);

    errs = err_cnt;
    dmem_access(clint_msip, 32'h1, 4'hf, 4, rd, ok, lat);
    require_ready(ok, "msip write");
    check_value("msip_o", 64'(msip_o), 64'h1);
    dmem_access(clint_msip, 32'h0, 4'hf, 4, rd, ok, lat);
    check_value("msip_o", 64'(msip_o), 64'h0);
    dmem_access(clint_time, '0, 4'h0, 4, t0, ok, lat);
    require_ready(ok, "mtime read");
    check_value("clint ready latency", 64'(lat), 64'd1);
    idle_cycles(200);
    dmem_access(clint_time, '0, 4'h0, 4, rd, ok, lat);
    check_value("mtime advance", 64'(rd - t0 >= 200 / rtc_div - 1), 64'h1);
    cmp_lo = 32'h0;
    cmp_hi = 32'h0;
    dmem_access(clint_cmp, cmp_lo, 4'hf, 4, rd, ok, lat);
    dmem_access(clint_cmph, cmp_hi, 4'hf, 4, rd, ok, lat);
    dmem_access(clint_time, '0, 4'h0, 4, lo, ok, lat);
    dmem_access(clint_timeh, '0, 4'h0, 4, hi, ok, lat);
    check_value("mtip_o", 64'(mtip_o), 64'(mtip_expected({hi, lo}, {cmp_hi, cmp_lo})));
    cmp_hi = 32'hffff_ffff;
    dmem_access(clint_cmph, cmp_hi, 4'hf, 4, rd, ok, lat);
    dmem_access(clint_time, '0, 4'h0, 4, lo, ok, lat);
    dmem_access(clint_timeh, '0, 4'h0, 4, hi, ok, lat);
    check_value("mtip_o", 64'(mtip_o), 64'(mtip_expected({hi, lo}, {cmp_hi, cmp_lo})));
    dmem_access(32'h3000_0000, '0, 4'h0, 10, rd, ok, lat);
    check_cnt++;
    if (ok) begin
      err_cnt++;
      $display("read of unmapped address 30000000 got a ready");
    end
    report_test("clint", errs);

    $display("%0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- files.f
soc_pkg.sv
mem_bus_if.sv
tick_divider.sv
bus_router.sv
bram.sv
uart_tx.sv
clint.sv
soc.sv
tb_soc.sv

//--- run.sh
#!/bin/sh
verilator --binary --assert -f files.f --top-module tb_soc -o tb_soc
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi
out=$(./obj_dir/tb_soc)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if echo "$out" | grep -q "All checks passed"; then
  exit 0
fi
exit 1
